// ==== design/asg_params.svh ====
// asg widths, defaults and register map
`ifndef ASG_PARAMS_SVH
`define ASG_PARAMS_SVH

`define ASG_RSZ        14                  // table address width
`define ASG_DW         14                  // sample and dac width
`define ASG_FRAC       16                  // pointer fraction bits
`define ASG_AW         20                  // decoded bus address bits

`define ASG_AMP_ONE    14'h2000            // unity gain
`define ASG_AMP_SHIFT  13
`define ASG_SIZE_RST   {(`ASG_RSZ+`ASG_FRAC){1'b1}}

// ----------------------------------------
// register offsets
`define ASG_A_CTRL     20'h00000           // shared by both channels
`define ASG_A_AMP      20'h00004
`define ASG_B_AMP      20'h00024
`define ASG_A_SIZE     20'h00008
`define ASG_B_SIZE     20'h00028
`define ASG_A_OFS      20'h0000C
`define ASG_B_OFS      20'h0002C
`define ASG_A_STEP     20'h00010
`define ASG_B_STEP     20'h00030
`define ASG_A_RPNT     20'h00060
`define ASG_B_RPNT     20'h00064

`define ASG_BUF_A_SEL  4'h1                // address bits 19:16
`define ASG_BUF_B_SEL  4'h2
`define ASG_BUF_RD_LAT 4                   // buffer read ack delay

`define ASG_SRC_SW     3'd1
`define ASG_SRC_EXT    3'd2

`endif

// ==== design/asg_pkg.sv ====
// asg shared types
`default_nettype none
`include "asg_params.svh"

package asg_pkg;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        wen;                      // single cycle write strobe
    logic        ren;                      // single cycle read strobe
  } asg_bus_req_t;

  // one channel half of the control word
  typedef struct packed {
    logic [3:0]  rsv_hi;                   // 15:12
    logic        temp;                     // temperature status
    logic        talm;                     // latched alarm
    logic        tpen;                     // protection enable
    logic        rsv_gate;
    logic        zero;                     // force output to 0
    logic        rst;                      // hold channel idle
    logic        once;
    logic        wrap;
    logic        rsv_lo;
    logic [2:0]  src;                      // trigger source
  } asg_ch_ctrl_t;

  typedef union packed {
    logic [31:0] raw;
    struct packed {
      asg_ch_ctrl_t b;                     // bits 31:16
      asg_ch_ctrl_t a;                     // bits 15:0
    } ch;
  } asg_ctrl_word_u;

  typedef struct packed {
    logic [`ASG_DW-1:0]            amp;    // unsigned with 0x2000 as unity
    logic [`ASG_DW-1:0]            dc;     // signed output offset
    logic [`ASG_RSZ+`ASG_FRAC-1:0] size;   // last pointer value
    logic [31:0]                   ofs;    // start pointer
    logic [31:0]                   step;
    asg_ch_ctrl_t                  ctrl;
  } asg_cfg_t;

  typedef struct packed {
    logic                we;
    logic [`ASG_RSZ-1:0] addr;
    logic [`ASG_DW-1:0]  data;
  } asg_buf_wr_t;

endpackage

`default_nettype wire

// ==== design/asg_reg_decode.sv ====
// asg register decode
`timescale 1ns/1ps
`default_nettype none
`include "asg_params.svh"

module asg_reg_decode (
  input  wire                        sys_clk,
  input  wire                        sys_rstn,
  input  wire asg_pkg::asg_bus_req_t bus_i,
  input  wire [1:0]                  temp_prot_i,
  input  wire [1:0]                  trig_ext_i,
  output asg_pkg::asg_cfg_t          cfg_a_o,
  output asg_pkg::asg_cfg_t          cfg_b_o,
  output logic [1:0]                 start_o,
  output asg_pkg::asg_buf_wr_t       buf_a_wr_o,
  output asg_pkg::asg_buf_wr_t       buf_b_wr_o,
  output logic [1:0]                 temp_sync_o
);

  localparam int RSZ  = `ASG_RSZ;
  localparam int DW   = `ASG_DW;
  localparam int FRAC = `ASG_FRAC;

  localparam logic [`ASG_AW-1:0] AMP_ADR  [2] = '{`ASG_A_AMP,  `ASG_B_AMP};
  localparam logic [`ASG_AW-1:0] SIZE_ADR [2] = '{`ASG_A_SIZE, `ASG_B_SIZE};
  localparam logic [`ASG_AW-1:0] OFS_ADR  [2] = '{`ASG_A_OFS,  `ASG_B_OFS};
  localparam logic [`ASG_AW-1:0] STEP_ADR [2] = '{`ASG_A_STEP, `ASG_B_STEP};

  logic [`ASG_AW-1:0]      adr;
  logic                    ctrl_wr;
  logic [3:0]              buf_sel;
  asg_pkg::asg_ctrl_word_u wr_word;
  asg_pkg::asg_ch_ctrl_t   wr_half [2];
  asg_pkg::asg_cfg_t       cfg_q [2];
  logic [1:0]              temp_meta;
  logic [1:0]              trig_q;
  logic [1:0]              buf_we_q;
  logic [RSZ-1:0]          buf_addr_q;
  logic [DW-1:0]           buf_data_q;

  assign adr        = bus_i.addr[`ASG_AW-1:0];
  assign buf_sel    = bus_i.addr[`ASG_AW-1:RSZ+2];
  assign ctrl_wr    = bus_i.wen && (adr == `ASG_A_CTRL);
  assign wr_word.raw = bus_i.wdata;
  assign wr_half[0] = wr_word.ch.a;
  assign wr_half[1] = wr_word.ch.b;

  // ----------------------------------------
  // configuration, alarm and start pulses
  always_ff @(posedge sys_clk) begin
    if (!sys_rstn) begin
      temp_meta   <= '0;
      temp_sync_o <= '0;
      trig_q      <= '0;
      start_o     <= '0;
      for (int ch = 0; ch < 2; ch++) begin
        cfg_q[ch]      <= '0;
        cfg_q[ch].amp  <= `ASG_AMP_ONE;
        cfg_q[ch].size <= `ASG_SIZE_RST;
      end
    end else begin
      temp_meta   <= temp_prot_i;          // two flop sync
      temp_sync_o <= temp_meta;
      trig_q      <= trig_ext_i;
      for (int ch = 0; ch < 2; ch++) begin
        start_o[ch] <= (ctrl_wr && (wr_half[ch].src == `ASG_SRC_SW)) ||
                       (trig_ext_i[ch] && !trig_q[ch] &&
                        (cfg_q[ch].ctrl.src == `ASG_SRC_EXT));
        if (ctrl_wr) begin
          cfg_q[ch].ctrl.src  <= wr_half[ch].src;
          cfg_q[ch].ctrl.wrap <= wr_half[ch].wrap;
          cfg_q[ch].ctrl.once <= wr_half[ch].once;
          cfg_q[ch].ctrl.rst  <= wr_half[ch].rst;
          cfg_q[ch].ctrl.zero <= wr_half[ch].zero;
          cfg_q[ch].ctrl.tpen <= wr_half[ch].tpen;
        end
        if (temp_sync_o[ch] && cfg_q[ch].ctrl.tpen) begin
          cfg_q[ch].ctrl.talm <= 1'b1;     // alarm wins over sw clear
        end else if (ctrl_wr) begin
          cfg_q[ch].ctrl.talm <= wr_half[ch].talm;
        end
        if (bus_i.wen) begin
          if (adr == AMP_ADR[ch]) begin
            cfg_q[ch].amp <= bus_i.wdata[DW-1:0];
            cfg_q[ch].dc  <= bus_i.wdata[16+DW-1:16];
          end
          if (adr == SIZE_ADR[ch]) cfg_q[ch].size <= bus_i.wdata[RSZ+FRAC-1:0];
          if (adr == OFS_ADR[ch])  cfg_q[ch].ofs  <= bus_i.wdata;
          if (adr == STEP_ADR[ch]) cfg_q[ch].step <= bus_i.wdata;
        end
      end
    end
  end

  // ----------------------------------------
  // table writes
  always_ff @(posedge sys_clk) begin
    if (!sys_rstn) begin
      buf_we_q <= '0;
    end else begin
      buf_we_q[0] <= bus_i.wen && (buf_sel == `ASG_BUF_A_SEL);
      buf_we_q[1] <= bus_i.wen && (buf_sel == `ASG_BUF_B_SEL);
    end
  end

  always_ff @(posedge sys_clk) begin
    if (bus_i.wen || bus_i.ren) begin      // held until the next access
      buf_addr_q <= bus_i.addr[RSZ+1:2];
      buf_data_q <= bus_i.wdata[DW-1:0];
    end
  end

  assign buf_a_wr_o = '{we: buf_we_q[0], addr: buf_addr_q, data: buf_data_q};
  assign buf_b_wr_o = '{we: buf_we_q[1], addr: buf_addr_q, data: buf_data_q};
  assign cfg_a_o    = cfg_q[0];
  assign cfg_b_o    = cfg_q[1];

endmodule

`default_nettype wire

// ==== design/asg_wave_table.sv ====
// asg waveform table
`timescale 1ns/1ps
`default_nettype none
`include "asg_params.svh"

module asg_wave_table (
  input  wire                        sys_clk,
  input  wire asg_pkg::asg_buf_wr_t  wr_i,
  input  wire [`ASG_RSZ-1:0]         bus_addr_i,
  output logic [`ASG_DW-1:0]         bus_rdata_o,
  input  wire [`ASG_RSZ-1:0]         rd_addr_i,
  output logic [`ASG_DW-1:0]         rd_data_o
);

  logic [`ASG_DW-1:0] mem [0:(1<<`ASG_RSZ)-1];

  // bus port for writes and readback
  always_ff @(posedge sys_clk) begin
    if (wr_i.we) begin
      mem[wr_i.addr] <= wr_i.data;
    end
    bus_rdata_o <= mem[bus_addr_i];
  end

  always_ff @(posedge sys_clk) begin
    rd_data_o <= mem[rd_addr_i];           // playback port
  end

endmodule

`default_nettype wire

// ==== design/asg_phase_acc.sv ====
// asg read pointer
`timescale 1ns/1ps
`default_nettype none
`include "asg_params.svh"

module asg_phase_acc (
  input  wire                              sys_clk,
  input  wire                              sys_rstn,
  input  wire asg_pkg::asg_cfg_t           cfg_i,
  input  wire                              start_i,
  output logic [`ASG_RSZ-1:0]              rd_addr_o,
  output logic [`ASG_RSZ+`ASG_FRAC-1:0]    rpnt_o
);

  localparam int PW = `ASG_RSZ + `ASG_FRAC;

  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } state_t;

  state_t        state_q;
  logic [PW-1:0] pnt_q;
  logic [PW:0]   pnt_add;                  // one spare bit for the carry
  logic [PW:0]   pnt_wrap;
  logic          past_end;

  assign pnt_add  = {1'b0, pnt_q} + {1'b0, cfg_i.step[PW-1:0]};
  assign pnt_wrap = pnt_add - ({1'b0, cfg_i.size} + 1'b1);
  assign past_end = pnt_add > {1'b0, cfg_i.size};

  always_ff @(posedge sys_clk) begin
    if (!sys_rstn || cfg_i.ctrl.rst) begin
      state_q <= ST_IDLE;
      pnt_q   <= '0;
    end else if (start_i) begin
      state_q <= ST_RUN;                   // retrigger restarts from ofs
      pnt_q   <= cfg_i.ofs[PW-1:0];
    end else if (state_q == ST_RUN) begin
      if (!past_end) begin
        pnt_q <= pnt_add[PW-1:0];
      end else if (cfg_i.ctrl.wrap) begin
        pnt_q <= pnt_wrap[PW-1:0];         // keep the fraction
      end else begin
        // once mode ends the run
        state_q <= ST_IDLE;
        pnt_q   <= '0;
      end
    end
  end

  assign rd_addr_o = pnt_q[PW-1:`ASG_FRAC];
  assign rpnt_o    = pnt_q;

endmodule

`default_nettype wire

// ==== design/asg_out_scale.sv ====
// asg output gain and offset
`timescale 1ns/1ps
`default_nettype none
`include "asg_params.svh"

module asg_out_scale (
  input  wire                     sys_clk,
  input  wire                     sys_rstn,
  input  wire [`ASG_DW-1:0]       sample_i,
  input  wire asg_pkg::asg_cfg_t  cfg_i,
  output logic [`ASG_DW-1:0]      dac_o
);

  localparam int DW = `ASG_DW;
  localparam int PW = 2*DW + 1;            // product width
  localparam int SW = PW - `ASG_AMP_SHIFT + 1;

  logic signed [PW-1:0] prod;
  logic [SW-1:0]        sum;
  logic [DW-1:0]        sat;

  assign prod = $signed(sample_i) * $signed({1'b0, cfg_i.amp});
  assign sum  = {prod[PW-1], prod[PW-1:`ASG_AMP_SHIFT]} +
                {{(SW-DW){cfg_i.dc[DW-1]}}, cfg_i.dc};

  always_comb begin
    if (!sum[SW-1] && (|sum[SW-2:DW-1])) begin
      sat = {1'b0, {(DW-1){1'b1}}};        // clip to max positive
    end else if (sum[SW-1] && !(&sum[SW-2:DW-1])) begin
      sat = {1'b1, {(DW-1){1'b0}}};        // clip to max negative
    end else begin
      sat = sum[DW-1:0];
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rstn) begin
      dac_o <= '0;
    end else if (cfg_i.ctrl.zero || cfg_i.ctrl.talm) begin
      dac_o <= '0;
    end else begin
      dac_o <= sat;
    end
  end

endmodule

`default_nettype wire

// ==== design/asg_bus_readback.sv ====
// asg bus readback
`timescale 1ns/1ps
`default_nettype none
`include "asg_params.svh"

module asg_bus_readback (
  input  wire                            sys_clk,
  input  wire                            sys_rstn,
  input  wire asg_pkg::asg_bus_req_t     bus_i,
  input  wire asg_pkg::asg_cfg_t         cfg_a_i,
  input  wire asg_pkg::asg_cfg_t         cfg_b_i,
  input  wire [1:0]                      temp_prot_i,
  input  wire [`ASG_RSZ+`ASG_FRAC-1:0]   rpnt_a_i,
  input  wire [`ASG_RSZ+`ASG_FRAC-1:0]   rpnt_b_i,
  input  wire [`ASG_DW-1:0]              buf_a_rdata_i,
  input  wire [`ASG_DW-1:0]              buf_b_rdata_i,
  output logic [31:0]                    sys_rdata_o,
  output logic                           sys_ack_o
);

  localparam int RSZ  = `ASG_RSZ;
  localparam int DW   = `ASG_DW;
  localparam int FRAC = `ASG_FRAC;
  localparam int LAT  = `ASG_BUF_RD_LAT;

  logic [`ASG_AW-1:0]      adr;
  logic [3:0]              sel;
  logic                    strobe;
  logic                    buf_hit;
  logic                    reg_ack;
  logic                    buf_b_q;        // last buffer access went to table b
  logic                    wr_dly;
  logic [LAT-2:0]          rd_dly;
  asg_pkg::asg_ctrl_word_u ctrl_rd;
  logic [31:0]             reg_rdata;

  assign adr     = bus_i.addr[`ASG_AW-1:0];
  assign sel     = bus_i.addr[`ASG_AW-1:RSZ+2];
  assign strobe  = bus_i.wen || bus_i.ren;
  assign buf_hit = (sel == `ASG_BUF_A_SEL) || (sel == `ASG_BUF_B_SEL);
  assign reg_ack = strobe && !buf_hit;

  // status bits ride on the stored control halves
  always_comb begin
    ctrl_rd.ch.a      = cfg_a_i.ctrl;
    ctrl_rd.ch.a.temp = temp_prot_i[0];
    ctrl_rd.ch.b      = cfg_b_i.ctrl;
    ctrl_rd.ch.b.temp = temp_prot_i[1];
  end

  always_comb begin
    case (adr)
      `ASG_A_CTRL: reg_rdata = ctrl_rd.raw;
      `ASG_A_AMP:  reg_rdata = {{(16-DW){1'b0}}, cfg_a_i.dc, {(16-DW){1'b0}}, cfg_a_i.amp};
      `ASG_B_AMP:  reg_rdata = {{(16-DW){1'b0}}, cfg_b_i.dc, {(16-DW){1'b0}}, cfg_b_i.amp};
      `ASG_A_SIZE: reg_rdata = {{(32-RSZ-FRAC){1'b0}}, cfg_a_i.size};
      `ASG_B_SIZE: reg_rdata = {{(32-RSZ-FRAC){1'b0}}, cfg_b_i.size};
      `ASG_A_OFS:  reg_rdata = cfg_a_i.ofs;
      `ASG_B_OFS:  reg_rdata = cfg_b_i.ofs;
      `ASG_A_STEP: reg_rdata = cfg_a_i.step;
      `ASG_B_STEP: reg_rdata = cfg_b_i.step;
      `ASG_A_RPNT: reg_rdata = {{(30-RSZ){1'b0}}, rpnt_a_i[RSZ+FRAC-1:FRAC], 2'b00};
      `ASG_B_RPNT: reg_rdata = {{(30-RSZ){1'b0}}, rpnt_b_i[RSZ+FRAC-1:FRAC], 2'b00};
      default:     reg_rdata = '0;         // unmapped
    endcase
  end

  // ----------------------------------------
  // acknowledge timing
  always_ff @(posedge sys_clk) begin
    if (!sys_rstn) begin
      sys_ack_o <= 1'b0;
      wr_dly    <= 1'b0;
      rd_dly    <= '0;
    end else begin
      wr_dly    <= bus_i.wen && buf_hit;
      rd_dly    <= {rd_dly[LAT-3:0], bus_i.ren && buf_hit};
      sys_ack_o <= reg_ack || wr_dly || rd_dly[LAT-2];
    end
  end

  always_ff @(posedge sys_clk) begin
    if (strobe && buf_hit) begin
      buf_b_q <= (sel == `ASG_BUF_B_SEL);
    end
    if (reg_ack) begin
      sys_rdata_o <= reg_rdata;
    end else if (rd_dly[LAT-2]) begin
      sys_rdata_o <= {{(32-DW){1'b0}}, buf_b_q ? buf_b_rdata_i : buf_a_rdata_i};
    end
  end

endmodule

`default_nettype wire

// ==== design/asg_top.sv ====
// asg two channel generator
`timescale 1ns/1ps
`default_nettype none
`include "asg_params.svh"

module asg_top (
  input  wire                 sys_clk,
  input  wire                 sys_rstn,
  input  wire [31:0]          sys_addr_i,
  input  wire [31:0]          sys_wdata_i,
  input  wire                 sys_wen_i,
  input  wire                 sys_ren_i,
  output wire [31:0]          sys_rdata_o,
  output wire                 sys_ack_o,
  input  wire                 trig_a_i,
  input  wire                 trig_b_i,
  input  wire [1:0]           temp_prot_i,
  output wire [`ASG_DW-1:0]   dac_a_o,
  output wire [`ASG_DW-1:0]   dac_b_o,
  output wire                 trig_out_o
);

  localparam int PW = `ASG_RSZ + `ASG_FRAC;

  asg_pkg::asg_bus_req_t bus_req;
  asg_pkg::asg_cfg_t     cfg [2];
  asg_pkg::asg_buf_wr_t  buf_wr [2];
  logic [1:0]            start;
  logic [1:0]            temp_sync;
  logic [`ASG_RSZ-1:0]   rd_addr [2];
  logic [PW-1:0]         rpnt [2];
  logic [`ASG_DW-1:0]    sample [2];
  logic [`ASG_DW-1:0]    buf_rdata [2];
  logic [`ASG_DW-1:0]    dac [2];

  assign bus_req = '{addr: sys_addr_i, wdata: sys_wdata_i, wen: sys_wen_i, ren: sys_ren_i};

  asg_reg_decode u_reg_decode (
    .sys_clk     (sys_clk),
    .sys_rstn    (sys_rstn),
    .bus_i       (bus_req),
    .temp_prot_i (temp_prot_i),
    .trig_ext_i  ({trig_b_i, trig_a_i}),
    .cfg_a_o     (cfg[0]),
    .cfg_b_o     (cfg[1]),
    .start_o     (start),
    .buf_a_wr_o  (buf_wr[0]),
    .buf_b_wr_o  (buf_wr[1]),
    .temp_sync_o (temp_sync)
  );

  // ----------------------------------------
  // per channel table, pointer and scaler
  for (genvar ch = 0; ch < 2; ch++) begin : g_ch
    asg_wave_table u_table (
      .sys_clk     (sys_clk),
      .wr_i        (buf_wr[ch]),
      .bus_addr_i  (buf_wr[ch].addr),      // bus reads share the write address
      .bus_rdata_o (buf_rdata[ch]),
      .rd_addr_i   (rd_addr[ch]),
      .rd_data_o   (sample[ch])
    );

    asg_phase_acc u_phase_acc (
      .sys_clk     (sys_clk),
      .sys_rstn    (sys_rstn),
      .cfg_i       (cfg[ch]),
      .start_i     (start[ch]),
      .rd_addr_o   (rd_addr[ch]),
      .rpnt_o      (rpnt[ch])
    );

    asg_out_scale u_out_scale (
      .sys_clk     (sys_clk),
      .sys_rstn    (sys_rstn),
      .sample_i    (sample[ch]),
      .cfg_i       (cfg[ch]),
      .dac_o       (dac[ch])
    );
  end

  asg_bus_readback u_bus_readback (
    .sys_clk       (sys_clk),
    .sys_rstn      (sys_rstn),
    .bus_i         (bus_req),
    .cfg_a_i       (cfg[0]),
    .cfg_b_i       (cfg[1]),
    .temp_prot_i   (temp_sync),
    .rpnt_a_i      (rpnt[0]),
    .rpnt_b_i      (rpnt[1]),
    .buf_a_rdata_i (buf_rdata[0]),
    .buf_b_rdata_i (buf_rdata[1]),
    .sys_rdata_o   (sys_rdata_o),
    .sys_ack_o     (sys_ack_o)
  );

  assign dac_a_o    = dac[0];
  assign dac_b_o    = dac[1];
  assign trig_out_o = start[0];            // channel a start notification

endmodule

`default_nettype wire

// ==== tests/asg_tb_clk.sv ====
// testbench clock source
`timescale 1ns/1ps
`default_nettype none

module asg_tb_clk #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;   // free running
  end

endmodule

`default_nettype wire

// ==== tests/asg_tb.sv ====
// asg generator testbench
`timescale 1ns/1ps
`default_nettype none
`include "asg_params.svh"

module asg_tb;

  localparam int ACK_TIMEOUT = 16;
  localparam int NWORDS      = 16;                 // table words under test
  localparam logic [31:0] BUF_A_BASE = {12'h000, `ASG_BUF_A_SEL, 16'h0000};
  localparam logic [31:0] BUF_B_BASE = {12'h000, `ASG_BUF_B_SEL, 16'h0000};

  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
  } reg_op_t;

  logic               sys_clk;
  logic               sys_rstn;
  logic [31:0]        sys_addr;
  logic [31:0]        sys_wdata;
  logic               sys_wen;
  logic               sys_ren;
  logic [31:0]        sys_rdata;
  logic               sys_ack;
  logic               trig_a;
  logic               trig_b;
  logic [1:0]         temp_prot;
  logic [`ASG_DW-1:0] dac_a;
  logic [`ASG_DW-1:0] dac_b;
  logic               trig_out;

  reg_op_t            reg_ops [$];
  logic [`ASG_DW-1:0] tab_a [NWORDS];
  logic [`ASG_DW-1:0] tab_b [NWORDS];
  logic [31:0]        rng;

  asg_tb_clk u_clk (.clk_o(sys_clk));

  asg_top dut (
    .sys_clk     (sys_clk),
    .sys_rstn    (sys_rstn),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack),
    .trig_a_i    (trig_a),
    .trig_b_i    (trig_b),
    .temp_prot_i (temp_prot),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b),
    .trig_out_o  (trig_out)
  );

  // ----------------------------------------
  // helpers
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // sample times gain over 2^13 plus dc with signed 14 bit clipping
  function automatic logic [13:0] scale_ref(input logic [13:0] smp, input logic [13:0] amp,
                                            input logic [13:0] dc);
    int s;
    int d;
    int r;
    s = $signed(smp);
    d = $signed(dc);
    r = ((s * int'(amp)) >>> 13) + d;
    if (r > 8191) r = 8191;
    if (r < -8192) r = -8192;
    return r[13:0];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // strobe and ack wait entered 1 ns after a rising edge
  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output int lat);
    sys_addr  = addr;
    sys_wdata = wdata;
    sys_wen   = wr;
    sys_ren   = !wr;
    @(posedge sys_clk);
    #1;
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    lat     = 1;
    while (!sys_ack && lat < ACK_TIMEOUT) begin
      @(posedge sys_clk);
      #1;
      lat++;
    end
    if (!sys_ack) begin
      abort_run($sformatf("no bus acknowledge for address %h", addr));
    end
    rdata = sys_rdata;
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    int          lat;
    bus_access(1'b1, addr, data, rdata, lat);
    check_value("sys_ack_o register latency", lat, 1);
  endtask

  task automatic reg_read_check(input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    int          lat;
    bus_access(1'b0, addr, 32'h0, rdata, lat);
    check_value("sys_ack_o register latency", lat, 1);
    check_value($sformatf("sys_rdata_o at %h", addr), rdata, exp);
  endtask

  // read until the masked value shows up
  task automatic poll_reg(input logic [31:0] addr, input logic [31:0] mask,
                          input logic [31:0] want, input string what);
    logic [31:0] rdata;
    int          lat;
    int          tries;
    bus_access(1'b0, addr, 32'h0, rdata, lat);
    tries = 1;
    while (((rdata & mask) !== want) && tries < 32) begin
      bus_access(1'b0, addr, 32'h0, rdata, lat);
      tries++;
    end
    if ((rdata & mask) !== want) begin
      abort_run($sformatf("timed out waiting for %s", what));
    end
  endtask

  task automatic add_op(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                        input logic [31:0] exp);
    reg_op_t op;
    op = '{wr: wr, addr: addr, data: data, exp: exp};
    reg_ops.push_back(op);
  endtask

  task automatic fill_reg_ops();
    add_op(1'b0, `ASG_A_CTRL, 0, 32'h0000_0000);       // reset values
    add_op(1'b0, `ASG_A_AMP,  0, 32'h0000_2000);
    add_op(1'b0, `ASG_B_AMP,  0, 32'h0000_2000);
    add_op(1'b0, `ASG_A_SIZE, 0, 32'h3FFF_FFFF);
    add_op(1'b0, `ASG_B_SIZE, 0, 32'h3FFF_FFFF);
    add_op(1'b0, `ASG_A_OFS,  0, 32'h0);
    add_op(1'b0, `ASG_B_OFS,  0, 32'h0);
    add_op(1'b0, `ASG_A_STEP, 0, 32'h0);
    add_op(1'b0, `ASG_B_STEP, 0, 32'h0);
    add_op(1'b0, `ASG_A_RPNT, 0, 32'h0);
    add_op(1'b0, `ASG_B_RPNT, 0, 32'h0);
    add_op(1'b0, 32'h40,      0, 32'h0);              // unmapped
    add_op(1'b1, `ASG_A_AMP,  32'h1F00_0123, 0);
    add_op(1'b1, `ASG_B_AMP,  32'h2100_3FFF, 0);
    add_op(1'b1, `ASG_A_SIZE, 32'h2ABC_DEF0, 0);
    add_op(1'b1, `ASG_B_SIZE, 32'h1234_5678, 0);
    add_op(1'b1, `ASG_A_OFS,  32'hDEAD_BEEF, 0);
    add_op(1'b1, `ASG_B_OFS,  32'h0BAD_F00D, 0);
    add_op(1'b1, `ASG_A_STEP, 32'h0001_8000, 0);
    add_op(1'b1, `ASG_B_STEP, 32'h7654_3210, 0);
    add_op(1'b1, `ASG_A_CTRL, 32'hFFF8_FFF8, 0);      // all bits but src
    add_op(1'b0, `ASG_A_AMP,  0, 32'h1F00_0123);
    add_op(1'b0, `ASG_B_AMP,  0, 32'h2100_3FFF);
    add_op(1'b0, `ASG_A_SIZE, 0, 32'h2ABC_DEF0);
    add_op(1'b0, `ASG_B_SIZE, 0, 32'h1234_5678);
    add_op(1'b0, `ASG_A_OFS,  0, 32'hDEAD_BEEF);
    add_op(1'b0, `ASG_B_OFS,  0, 32'h0BAD_F00D);
    add_op(1'b0, `ASG_A_STEP, 0, 32'h0001_8000);
    add_op(1'b0, `ASG_B_STEP, 0, 32'h7654_3210);
    add_op(1'b0, `ASG_A_CTRL, 0, 32'h06F0_06F0);      // reserved and temp read 0
    add_op(1'b1, `ASG_A_CTRL, 32'h0, 0);
    add_op(1'b0, `ASG_A_CTRL, 0, 32'h0);
  endtask

  // ----------------------------------------
  // main sequence
  initial begin
    logic [31:0] rdata;
    int          lat;
    int          n;
    logic [13:0] amps [3];
    logic [13:0] dcs [3];
    sys_rstn  = 1'b0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    trig_a    = 1'b0;
    trig_b    = 1'b0;
    temp_prot = 2'b00;
    rng       = 32'hbf67;
    amps[0]   = 14'h3000;                             // gain 1.5 with a small offset
    dcs[0]    = 14'h0100;
    amps[1]   = 14'h3FFF;                             // drives positive clipping
    dcs[1]    = 14'h1F00;
    amps[2]   = 14'h1000;                             // negative offset
    dcs[2]    = 14'h2100;
    repeat (10) @(posedge sys_clk);
    #1;
    sys_rstn = 1'b1;

    fill_reg_ops();
    foreach (reg_ops[i]) begin
      bus_access(reg_ops[i].wr, reg_ops[i].addr, reg_ops[i].data, rdata, lat);
      check_value("sys_ack_o register latency", lat, 1);
      if (!reg_ops[i].wr) begin
        check_value($sformatf("sys_rdata_o at %h", reg_ops[i].addr), rdata, reg_ops[i].exp);
      end
    end

    // random table contents
    for (int i = 0; i < NWORDS; i++) begin
      rng      = xorshift(rng);
      tab_a[i] = rng[13:0];
      bus_access(1'b1, BUF_A_BASE + i*4, rng, rdata, lat);
      check_value("sys_ack_o buffer write latency", lat, 2);
      rng      = xorshift(rng);
      tab_b[i] = rng[13:0];
      bus_access(1'b1, BUF_B_BASE + i*4, rng, rdata, lat);
      check_value("sys_ack_o buffer write latency", lat, 2);
    end
    for (int i = 0; i < NWORDS; i++) begin
      bus_access(1'b0, BUF_A_BASE + i*4, 32'h0, rdata, lat);
      check_value("sys_ack_o buffer read latency", lat, `ASG_BUF_RD_LAT);
      check_value("table a sys_rdata_o", rdata, {18'h0, tab_a[i]});
      bus_access(1'b0, BUF_B_BASE + i*4, 32'h0, rdata, lat);
      check_value("sys_ack_o buffer read latency", lat, `ASG_BUF_RD_LAT);
      check_value("table b sys_rdata_o", rdata, {18'h0, tab_b[i]});
    end

    // ----------------------------------------
    // channel a wrap playback
    reg_write(`ASG_A_SIZE, 32'h0007_0000);
    reg_write(`ASG_A_STEP, 32'h0001_0000);
    reg_write(`ASG_A_OFS,  32'h0);
    reg_write(`ASG_A_AMP,  32'h0000_2000);
    reg_write(`ASG_A_CTRL, 32'h0000_0011);          // sw start and wrap on a
    check_value("trig_out_o", trig_out, 1);
    @(posedge sys_clk);
    #1;
    check_value("trig_out_o", trig_out, 0);
    n = 0;
    while (dac_a !== tab_a[1] && n < 20) begin      // idle already shows entry 0
      @(posedge sys_clk);
      #1;
      n++;
    end
    if (dac_a !== tab_a[1]) abort_run("channel a never played table entry 1");
    for (int k = 2; k <= 9; k++) begin
      @(posedge sys_clk);
      #1;
      check_value("dac_a_o", dac_a, tab_a[k % 8]);
    end

    // channel b scaling per table index
    reg_write(`ASG_B_STEP, 32'h0);
    reg_write(`ASG_B_SIZE, 32'h000F_0000);
    for (int s = 0; s < 3; s++) begin
      reg_write(`ASG_B_AMP, {2'b00, dcs[s], 2'b00, amps[s]});
      for (int i = 0; i < 6; i++) begin
        reg_write(`ASG_B_OFS, i << 16);
        reg_write(`ASG_A_CTRL, 32'h0001_0040);      // sw start on b with a held in rst
        repeat (4) @(posedge sys_clk);
        #1;
        check_value("dac_b_o", dac_b, scale_ref(tab_b[i], amps[s], dcs[s]));
      end
    end
    reg_write(`ASG_A_CTRL, 32'h0080_0040);          // zero on b
    repeat (2) @(posedge sys_clk);
    #1;
    check_value("dac_b_o", dac_b, 0);

    // ----------------------------------------
    // once mode on an external edge
    reg_write(`ASG_A_SIZE, 32'h0003_0000);
    reg_write(`ASG_A_CTRL, 32'h0080_0022);          // ext source and once on a
    trig_a = 1'b1;
    poll_reg(`ASG_A_RPNT, 32'hFFFF_FFFF, 32'h8, "channel a pointer to reach 2");
    poll_reg(`ASG_A_RPNT, 32'hFFFF_FFFF, 32'h0, "channel a to stop");
    trig_a = 1'b0;
    repeat (10) @(posedge sys_clk);
    #1;
    reg_read_check(`ASG_A_RPNT, 32'h0);
    check_value("dac_a_o", dac_a, tab_a[0]);

    // temperature alarm
    reg_write(`ASG_A_CTRL, 32'h0000_0200);          // tpen on a
    temp_prot = 2'b01;
    poll_reg(`ASG_A_CTRL, 32'h0000_0400, 32'h0000_0400, "talm to latch");
    reg_read_check(`ASG_A_CTRL, 32'h0000_0E00);
    repeat (2) @(posedge sys_clk);
    #1;
    check_value("dac_a_o", dac_a, 0);
    temp_prot = 2'b00;
    poll_reg(`ASG_A_CTRL, 32'h0000_0800, 32'h0, "temp status to clear");
    reg_read_check(`ASG_A_CTRL, 32'h0000_0600);     // alarm stays latched
    check_value("dac_a_o", dac_a, 0);

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+design
design/asg_pkg.sv
design/asg_reg_decode.sv
design/asg_wave_table.sv
design/asg_phase_acc.sv
design/asg_out_scale.sv
design/asg_bus_readback.sv
design/asg_top.sv
tests/asg_tb_clk.sv
tests/asg_tb.sv

// ==== Bender.yml ====
package:
  name: asg

export_include_dirs:
  - design

sources:
  - files:
      - design/asg_pkg.sv
      - design/asg_reg_decode.sv
      - design/asg_wave_table.sv
      - design/asg_phase_acc.sv
      - design/asg_out_scale.sv
      - design/asg_bus_readback.sv
      - design/asg_top.sv
  - target: test
    files:
      - tests/asg_tb_clk.sv
      - tests/asg_tb.sv
